/* bench/async_fifo_checker.sv */
module async_fifo_checker (
  input logic                     wr_clk,
  input logic                     wr_rst_n,
  input logic                     rd_clk,
  input logic                     rd_rst_n,
  input logic                     full,
  input logic                     afull,
  input logic                     empty,
  input logic                     aempty,
  input logic [cdc_pkg::ADDR_W:0] wr_ptr,
  input logic [cdc_pkg::ADDR_W:0] rd_ptr
);

  // flags sit at their reset values while each domain is held.
  full_in_reset: assert property (@(posedge wr_clk) !wr_rst_n |-> !full && !afull)
    else $error("full or afull set while the write side is in reset");
  empty_in_reset: assert property (@(posedge rd_clk) !rd_rst_n |-> empty && aempty)
    else $error("empty or aempty cleared while the read side is in reset");

  // a full fifo takes no write, an empty one gives no read.
  wr_ptr_held: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    full |=> $stable(wr_ptr))
    else $error("write pointer moved while full");
  rd_ptr_held: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    empty |=> $stable(rd_ptr))
    else $error("read pointer moved while empty");

  full_has_afull: assert property (@(posedge wr_clk) disable iff (!wr_rst_n) full |-> afull)
    else $error("full without afull");
  empty_has_aempty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n) empty |-> aempty)
    else $error("empty without aempty");

endmodule

bind async_fifo async_fifo_checker u_checker (
  .wr_clk   (wr_clk),
  .wr_rst_n (wr_rst_n),
  .rd_clk   (rd_clk),
  .rd_rst_n (rd_rst_n),
  .full     (full),
  .afull    (afull),
  .empty    (empty),
  .aempty   (aempty),
  .wr_ptr   (wr_ptr),
  .rd_ptr   (rd_ptr)
);

/* bench/clk_gen.sv */
module clk_gen #(
  parameter int PERIOD = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2);
      clk = ~clk;  // half period per phase.
    end
  end

endmodule

/* bench/sample_cdc_tb.sv */
module sample_cdc_tb;

  import cdc_pkg::*;

  typedef struct {
    string            name;
    int               n_wr;
    bit               hold;       // reads held off during the writes.
    bit               drain;
    bit               rand_gap;
    int               exp_dlv;
    int               exp_ovf;
    logic [SEQ_W-1:0] exp_gap;    // first entry delivered in the row.
    bit               chk_flags;
    logic [2:0]       exp_flags;  // {full, afull, aempty}.
  } test_row_t;

  logic                wr_clk;
  logic                rd_clk;
  logic                wr_rst_n;
  logic                rd_rst_n;
  logic                in_valid;
  logic [SAMPLE_W-1:0] in_sample;
  logic                rd_en;
  logic                out_valid;
  egress_t             out_entry;
  logic                full;
  logic                afull;
  logic                overflow;
  logic                empty;
  logic                aempty;

  test_row_t        rows [6];
  egress_t          model_q [$];
  egress_t          got_mem [256];
  int               got_cnt = 0;
  int               ovf_total = 0;
  int               errors = 0;
  int               passed = 0;
  int               failed = 0;
  int               seed = 32'h8e3624a1;
  int               lost_run = 0;  // writes dropped since the last stored one.

  clk_gen #(.PERIOD(40)) u_wr_clk_gen (.clk(wr_clk));
  clk_gen #(.PERIOD(60)) u_rd_clk_gen (.clk(rd_clk));

  sample_cdc_top u_sample_cdc_top (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .in_valid  (in_valid),
    .in_sample (in_sample),
    .rd_en     (rd_en),
    .out_valid (out_valid),
    .out_entry (out_entry),
    .full      (full),
    .afull     (afull),
    .overflow  (overflow),
    .empty     (empty),
    .aempty    (aempty)
  );

  // capture on the falling edge, away from the register updates.
  always @(negedge rd_clk) begin
    if (out_valid) begin
      got_mem[8'(got_cnt)] = out_entry;
      got_cnt = got_cnt + 1;
    end
  end

  always @(negedge wr_clk) begin
    if (overflow) begin
      ovf_total = ovf_total + 1;
    end
  end

  task automatic check_count(input string what, input int got, input int want);
    assert (got == want) else begin
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, want);
      errors++;
    end
  endtask

  task automatic check_reset_state();
    assert ({empty, aempty, full, afull, out_valid} == 5'b11000) else begin
      $display("Mismatch at %0t: {empty,aempty,full,afull,out_valid} is %b after reset",
               $time, {empty, aempty, full, afull, out_valid});
      errors++;
    end
  endtask

  // model keeps 16 entries while reads are held and drops the rest.
  task automatic drive_writes(input int count, input bit hold, input bit rand_gap);
    int      idle;
    egress_t ent;
    for (int i = 0; i < count; i++) begin
      @(posedge wr_clk);
      ent.sample = SAMPLE_W'($random(seed));
      in_valid  <= 1'b1;
      in_sample <= ent.sample;
      if (hold && model_q.size() >= FIFO_DEPTH) begin
        lost_run = lost_run + 1;
      end else begin
        ent.gap = SEQ_W'(lost_run);  // drops since the previous stored write.
        model_q.push_back(ent);
        lost_run = 0;
      end
      if (rand_gap) begin
        idle = 1 + ($random(seed) & 3);
        repeat (idle) begin
          @(posedge wr_clk);
          in_valid <= 1'b0;
        end
      end
    end
    @(posedge wr_clk);
    in_valid <= 1'b0;
    repeat (2) @(posedge wr_clk);  // tagger stage flush.
  endtask

  task automatic poll_flags(input string name, input logic [2:0] want);
    int n;
    n = 0;
    do begin
      @(negedge wr_clk);
      n++;
    end while ({full, afull, aempty} != want && n < 50);
    assert ({full, afull, aempty} == want) else begin
      $display("Mismatch at %0t: %s {full,afull,aempty} is %b, expected %b",
               $time, name, {full, afull, aempty}, want);
      errors++;
    end
  endtask

  task automatic await_delivery(input string name, input int target);
    int n;
    n = 0;
    while (got_cnt < target && n < 500) begin
      @(negedge rd_clk);
      n++;
    end
    if (got_cnt < target) begin
      $display("timeout in test %s: only %0d of %0d entries came out", name, got_cnt, target);
      errors++;
    end
  endtask

  task automatic settle_empty(input string name);
    int n;
    n = 0;
    do begin
      @(negedge rd_clk);
      n++;
    end while (!empty && n < 50);
    assert (empty) else begin
      $display("timeout in test %s: the FIFO never went empty", name);
      errors++;
    end
  endtask

  task automatic score_deliveries(input string name, input int first, input int last,
                                  input logic [SEQ_W-1:0] first_gap);
    egress_t ent;
    for (int i = first; i < last; i++) begin
      if (model_q.size() == 0) begin
        $display("test %s delivered an entry that was never written", name);
        errors++;
      end else begin
        ent = model_q.pop_front();
        assert (got_mem[8'(i)].sample == ent.sample && got_mem[8'(i)].gap == ent.gap) else begin
          $display("Mismatch at %0t: %s entry %0d is %h/%0d, expected %h/%0d", $time, name,
                   i - first, got_mem[8'(i)].sample, got_mem[8'(i)].gap, ent.sample, ent.gap);
          errors++;
        end
        if (i == first) begin
          check_count({name, " first gap"}, int'(got_mem[8'(i)].gap), int'(first_gap));
        end
      end
    end
  endtask

  task automatic log_result(input string name, input int err_start);
    if (errors == err_start) begin
      passed++;
      $display("test %-10s ok", name);
    end else begin
      failed++;
      $display("test %-10s failed with %0d errors", name, errors - err_start);
    end
  endtask

  initial begin
    int row_start;
    int dlv_start;
    int ovf_start;
    wr_rst_n  = 1'b1;
    rd_rst_n  = 1'b1;
    in_valid  = 1'b0;
    in_sample = '0;
    rd_en     = 1'b0;
    rows[0] = '{"in_order",   10, 1'b0, 1'b1, 1'b0, 10, 0, 8'd0, 1'b0, 3'b000};
    rows[1] = '{"fill",       15, 1'b1, 1'b0, 1'b0,  0, 0, 8'd0, 1'b1, 3'b010};
    rows[2] = '{"top_off",     1, 1'b1, 1'b0, 1'b0,  0, 0, 8'd0, 1'b1, 3'b110};
    rows[3] = '{"overflow",    4, 1'b1, 1'b1, 1'b0, 16, 4, 8'd0, 1'b1, 3'b110};
    rows[4] = '{"resume",      1, 1'b0, 1'b1, 1'b0,  1, 0, 8'd4, 1'b0, 3'b000};
    rows[5] = '{"concurrent", 60, 1'b0, 1'b1, 1'b1, 60, 0, 8'd0, 1'b0, 3'b000};

    #1;
    wr_rst_n = 1'b0;  // clear both domains before the first edge.
    rd_rst_n = 1'b0;
    row_start = errors;
    repeat (4) begin
      @(negedge wr_clk);
      check_reset_state();
    end
    @(posedge wr_clk);
    wr_rst_n <= 1'b1;
    rd_rst_n <= 1'b1;
    @(posedge rd_clk);  // both domains clock once out of reset.
    @(negedge rd_clk);
    check_reset_state();
    log_result("reset", row_start);

    foreach (rows[r]) begin
      row_start = errors;
      dlv_start = got_cnt;
      ovf_start = ovf_total;
      @(posedge rd_clk);
      rd_en <= ~rows[r].hold;
      drive_writes(rows[r].n_wr, rows[r].hold, rows[r].rand_gap);
      if (rows[r].chk_flags) begin
        poll_flags(rows[r].name, rows[r].exp_flags);
      end
      check_count({rows[r].name, " overflow pulses"}, ovf_total - ovf_start, rows[r].exp_ovf);
      if (rows[r].drain) begin
        @(posedge rd_clk);
        rd_en <= 1'b1;
        await_delivery(rows[r].name, dlv_start + rows[r].exp_dlv);
        settle_empty(rows[r].name);
      end
      check_count({rows[r].name, " deliveries"}, got_cnt - dlv_start, rows[r].exp_dlv);
      score_deliveries(rows[r].name, dlv_start, got_cnt, rows[r].exp_gap);
      log_result(rows[r].name, row_start);
    end

    $display("summary: %0d tests passed, %0d failed, %0d errors", passed, failed, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* run.sh */
#!/bin/sh
# build and run the testbench with verilator.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module sample_cdc_tb \
  -f sample_cdc_top.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* sample_cdc_top.f */
src/cdc_pkg.sv
src/dualport_ram_async.sv
src/gray_sync.sv
src/async_fifo.sv
src/sample_tagger.sv
src/seq_monitor.sv
src/sample_cdc_top.sv
bench/clk_gen.sv
bench/async_fifo_checker.sv
bench/sample_cdc_tb.sv

/* src/async_fifo.sv */
module async_fifo #(
  parameter type payload_t = cdc_pkg::tagged_sample_t
) (
  // write side.
  input  logic     wr_clk,
  input  logic     wr_rst_n,
  input  logic     wr_en,
  input  payload_t wr_data,
  output logic     full,
  output logic     afull,
  output logic     overflow,
  // read side.
  input  logic     rd_clk,
  input  logic     rd_rst_n,
  input  logic     rd_en,
  output payload_t rd_data,
  output logic     rd_fire,
  output logic     empty,
  output logic     aempty
);

  import cdc_pkg::*;

  logic            wr_vld;
  logic [ADDR_W:0] wr_ptr;
  logic [ADDR_W:0] wr_ptr_nxt;
  logic [ADDR_W:0] wr_gray;
  logic [ADDR_W:0] wr_gray_nxt;
  logic [ADDR_W:0] rd_ptr_wsync;  // read pointer seen in wr_clk.
  logic [ADDR_W:0] used_wr_nxt;

  logic            rd_vld;
  logic [ADDR_W:0] rd_ptr;
  logic [ADDR_W:0] rd_ptr_nxt;
  logic [ADDR_W:0] rd_gray;
  logic [ADDR_W:0] rd_gray_nxt;
  logic [ADDR_W:0] wr_ptr_rsync;  // write pointer seen in rd_clk.
  logic [ADDR_W:0] used_rd_nxt;

  assign wr_vld   = wr_en && !full;
  assign rd_vld   = rd_en && !empty;
  assign overflow = wr_en && full;   // dropped write.

  dualport_ram_async #(
    .payload_t (payload_t)
  ) u_ram (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_vld),
    .wr_addr  (wr_ptr[ADDR_W-1:0]),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_vld),
    .rd_addr  (rd_ptr[ADDR_W-1:0]),
    .rd_data  (rd_data)
  );

  gray_sync u_rd2wr (
    .clk     (wr_clk),
    .rst_n   (wr_rst_n),
    .gray_in (rd_gray),
    .bin_out (rd_ptr_wsync)
  );

  gray_sync u_wr2rd (
    .clk     (rd_clk),
    .rst_n   (rd_rst_n),
    .gray_in (wr_gray),
    .bin_out (wr_ptr_rsync)
  );

  // write domain.
  assign wr_ptr_nxt  = wr_ptr + (ADDR_W+1)'(wr_vld);
  assign wr_gray_nxt = (wr_ptr_nxt >> 1) ^ wr_ptr_nxt;
  assign used_wr_nxt = wr_ptr_nxt - rd_ptr_wsync; // stale read ptr overstates usage.

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr  <= '0;
      wr_gray <= '0;
      full    <= 1'b0;
      afull   <= 1'b0;
    end else begin
      wr_ptr  <= wr_ptr_nxt;
      wr_gray <= wr_gray_nxt;
      full    <= (used_wr_nxt == (ADDR_W+1)'(FIFO_DEPTH));
      afull   <= (used_wr_nxt >= (ADDR_W+1)'(FIFO_AFULL));
    end
  end

  // read domain.
  assign rd_ptr_nxt  = rd_ptr + (ADDR_W+1)'(rd_vld);
  assign rd_gray_nxt = (rd_ptr_nxt >> 1) ^ rd_ptr_nxt;
  assign used_rd_nxt = wr_ptr_rsync - rd_ptr_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr  <= '0;
      rd_gray <= '0;
      rd_fire <= 1'b0;
      empty   <= 1'b1;
      aempty  <= 1'b1;
    end else begin
      rd_ptr  <= rd_ptr_nxt;
      rd_gray <= rd_gray_nxt;
      rd_fire <= rd_vld;  // lines up with rd_data.
      empty   <= (used_rd_nxt == '0);
      aempty  <= (used_rd_nxt <= (ADDR_W+1)'(FIFO_AEMPTY));
    end
  end

endmodule

/* src/cdc_pkg.sv */
package cdc_pkg;

  // sample and tag widths.
  localparam int SAMPLE_W = 8;
  localparam int SEQ_W    = 8;   // wraps modulo 256.

  // fifo geometry.
  localparam int FIFO_DEPTH = 16;
  localparam int ADDR_W     = 4;  // pointers carry one extra wrap bit.

  // flag thresholds on the used-count.
  localparam int FIFO_AFULL  = 15;
  localparam int FIFO_AEMPTY = 1;

  // entry stored in the fifo.
  typedef struct packed {
    logic [SEQ_W-1:0]    seq;
    logic [SAMPLE_W-1:0] sample;
  } tagged_sample_t;

  // entry delivered on the read side.
  typedef struct packed {
    logic [SAMPLE_W-1:0] sample;
    logic [SEQ_W-1:0]    gap;   // seq numbers lost before this one.
  } egress_t;

endpackage

/* src/dualport_ram_async.sv */
module dualport_ram_async #(
  parameter type payload_t = cdc_pkg::tagged_sample_t
) (
  input  logic                      wr_clk,
  input  logic                      wr_rst_n,
  input  logic                      wr_en,
  input  logic [cdc_pkg::ADDR_W-1:0] wr_addr,
  input  payload_t                  wr_data,
  input  logic                      rd_clk,
  input  logic                      rd_rst_n,
  input  logic                      rd_en,
  input  logic [cdc_pkg::ADDR_W-1:0] rd_addr,
  output payload_t                  rd_data
);

  import cdc_pkg::*;

  payload_t mem [FIFO_DEPTH];

  // write port.
  // no writes land while the write domain sits in reset.
  always_ff @(posedge wr_clk) begin
    if (wr_en && wr_rst_n) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read port, cleared by the read reset.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr]; // valid one rd_clk later.
    end
  end

endmodule

/* src/gray_sync.sv */
module gray_sync (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [cdc_pkg::ADDR_W:0] gray_in,
  output logic [cdc_pkg::ADDR_W:0] bin_out
);

  import cdc_pkg::*;

  logic [ADDR_W:0] sync_q1;
  logic [ADDR_W:0] sync_q2;

  // two flop stages into the destination clock.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= gray_in;
      sync_q2 <= sync_q1;
    end
  end

  // gray back to binary, msb down.
  always_comb begin
    bin_out[ADDR_W] = sync_q2[ADDR_W];
    for (int i = ADDR_W - 1; i >= 0; i--) begin
      bin_out[i] = bin_out[i+1] ^ sync_q2[i];
    end
  end

endmodule

/* src/sample_cdc_top.sv */
module sample_cdc_top (
  input  logic                        wr_clk,
  input  logic                        wr_rst_n,
  input  logic                        rd_clk,
  input  logic                        rd_rst_n,
  input  logic                        in_valid,
  input  logic [cdc_pkg::SAMPLE_W-1:0] in_sample,
  input  logic                        rd_en,
  output logic                        out_valid,
  output cdc_pkg::egress_t            out_entry,
  output logic                        full,
  output logic                        afull,
  output logic                        overflow,
  output logic                        empty,
  output logic                        aempty
);

  import cdc_pkg::*;

  logic           tag_valid;
  tagged_sample_t tag_entry;
  tagged_sample_t rd_data;
  logic           rd_fire;

  sample_tagger u_tagger (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .in_valid  (in_valid),
    .in_sample (in_sample),
    .tag_valid (tag_valid),
    .tag_entry (tag_entry)
  );

  async_fifo #(
    .payload_t (tagged_sample_t)
  ) u_fifo (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (tag_valid),
    .wr_data  (tag_entry),
    .full     (full),
    .afull    (afull),
    .overflow (overflow),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .rd_fire  (rd_fire),
    .empty    (empty),
    .aempty   (aempty)
  );

  seq_monitor u_monitor (
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .in_fire   (rd_fire),
    .in_entry  (rd_data),
    .out_valid (out_valid),
    .out_entry (out_entry)
  );

endmodule

/* src/sample_tagger.sv */
module sample_tagger (
  input  logic                        wr_clk,
  input  logic                        wr_rst_n,
  input  logic                        in_valid,
  input  logic [cdc_pkg::SAMPLE_W-1:0] in_sample,
  output logic                        tag_valid,
  output cdc_pkg::tagged_sample_t     tag_entry
);

  import cdc_pkg::*;

  logic [SEQ_W-1:0] seq;

  // counter advances on every accepted input.
  // drops further down the path do not hold it back.
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      seq       <= '0;
      tag_valid <= 1'b0;
    end else begin
      tag_valid <= in_valid;
      if (in_valid) begin
        seq <= seq + SEQ_W'(1);
      end
    end
  end

  // stamp the sample with the count it arrived under.
  always_ff @(posedge wr_clk) begin
    if (in_valid) begin
      tag_entry.seq    <= seq;
      tag_entry.sample <= in_sample;
    end
  end

endmodule

/* src/seq_monitor.sv */
module seq_monitor (
  input  logic                    rd_clk,
  input  logic                    rd_rst_n,
  input  logic                    in_fire,
  input  cdc_pkg::tagged_sample_t in_entry,
  output logic                    out_valid,
  output cdc_pkg::egress_t        out_entry
);

  import cdc_pkg::*;

  logic [SEQ_W-1:0] last_seq;
  logic             seen_first;
  logic [SEQ_W-1:0] gap;

  // seq numbers missing between this entry and the previous one.
  always_comb begin
    if (seen_first) begin
      gap = in_entry.seq - last_seq - SEQ_W'(1);  // modulo 256.
    end else begin
      gap = '0;
    end
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      last_seq   <= '0;
      seen_first <= 1'b0;
      out_valid  <= 1'b0;
    end else begin
      out_valid <= in_fire;
      if (in_fire) begin
        last_seq   <= in_entry.seq;
        seen_first <= 1'b1;
      end
    end
  end

  // delivered entry, held until the next fire.
  always_ff @(posedge rd_clk) begin
    if (in_fire) begin
      out_entry.sample <= in_entry.sample;
      out_entry.gap    <= gap;
    end
  end

endmodule
